// File: bench/alu_issue_checks.svh
`ifndef ALU_ISSUE_CHECKS_SVH
`define ALU_ISSUE_CHECKS_SVH

    // Check counters, indexed by behavior number.
    int pass_cnt [1:6];
    int fail_cnt [1:6];

    function automatic string test_label(input int t);
        case (t)
            1:       return "reset state";
            2:       return "immediate operands";
            3:       return "GRF operands";
            4:       return "ALU slot bypass";
            5:       return "unit priority";
            default: return "back-pressure and order";
        endcase
    endfunction

    task automatic check_exe(input exe_instr_t got, input exe_instr_t exp, input int t,
                             input string name);
        if (got === exp) begin
            pass_cnt[t]++;
        end else begin
            fail_cnt[t]++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_operand(input operand_t got, input operand_t exp, input int t,
                                 input string name);
        if (got === exp) begin
            pass_cnt[t]++;
        end else begin
            fail_cnt[t]++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input int t,
                              input string name);
        if (got === exp) begin
            pass_cnt[t]++;
        end else begin
            fail_cnt[t]++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic report_test(input int t);
        $display("test %0d (%s): %0d checks, %0d errors", t, test_label(t),
                 pass_cnt[t] + fail_cnt[t], fail_cnt[t]);
    endtask

`endif

// File: bench/alu_issue_tb.sv
`timescale 1ns/1ps

`include "alu_issue_params.svh"

module alu_issue_tb
    import alu_issue_pkg::*;
();

    localparam int NUM_INSTR   = 400;
    localparam int CYCLE_LIMIT = NUM_INSTR * 10 + 200;
    localparam int OPW         = `ALU_OPERAND_W;

    logic            w_IssueFifoFire_1;
    logic            rstn;
    logic            i_valid;
    alu_instr_t      i_instr;
    logic            o_ready;
    logic            o_grf_rd_en;
    reg_addr_t       o_grf_rs1;
    reg_addr_t       o_grf_rs2;
    operand_t        i_grf_rdata_l;
    operand_t        i_grf_rdata_r;
    alu_bypass_bus_t i_alu_bypass;
    unit_index_t     i_lsu_index;
    operand_t        i_lsu_data;
    unit_index_t     i_csr_index;
    operand_t        i_csr_data;
    unit_index_t     i_mul_index;
    operand_t        i_mul_data;
    unit_index_t     i_div_index;
    operand_t        i_div_data;
    logic            o_valid;
    exe_instr_t      o_exe_instr;
    logic            i_exe_ready;

    // Accepted but not yet read from the GRF.
    alu_instr_t pend_q[$];
    exe_instr_t exp_q[$];
    int         cat_l_q[$];
    int         cat_r_q[$];

    int         sent;
    int         received;
    int         cycles;
    logic       timed_out;
    logic       hold_check;
    exe_instr_t held_word;

    `include "alu_issue_checks.svh"

    alu_issue_top UUT (.*);

    initial begin
        w_IssueFifoFire_1 = 1'b0;
    end

    always #2 w_IssueFifoFire_1 = ~w_IssueFifoFire_1;

    function automatic operand_t grf_value(input reg_addr_t addr, input logic left);
        if (left) begin
            return {16'hA1C3, 11'd0, addr};
        end
        return {16'h5E27, 6'd0, addr, addr};
    endfunction

    // GRF answers combinationally.
    assign i_grf_rdata_l = grf_value(o_grf_rs1, 1'b1);
    assign i_grf_rdata_r = grf_value(o_grf_rs2, 1'b0);

    function automatic alu_instr_t make_instr();
        logic [127:0] raw;
        alu_instr_t   ins;
        raw = {$urandom, $urandom, $urandom, $urandom};
        ins = raw[`ALU_INSTR_W-1:0];
        ins[`ALU_F_IMM_L_HI] = ($urandom_range(3) == 0);
        ins[`ALU_F_IMM_R_HI] = ($urandom_range(3) == 0);
        if ($urandom_range(3) == 0) begin
            ins[`ALU_F_DEP_L_HI:`ALU_F_DEP_L_LO] = dep_tag_t'(`ALU_TAG_NONE);
        end else begin
            ins[`ALU_F_DEP_L_HI:`ALU_F_DEP_L_LO] = dep_tag_t'($urandom_range(14));
        end
        if ($urandom_range(3) == 0) begin
            ins[`ALU_F_DEP_R_HI:`ALU_F_DEP_R_LO] = dep_tag_t'(`ALU_TAG_NONE);
        end else begin
            ins[`ALU_F_DEP_R_HI:`ALU_F_DEP_R_LO] = dep_tag_t'($urandom_range(14));
        end
        return ins;
    endfunction

    // Often lands on one of the stage-1 tags.
    function automatic unit_index_t pick_index(input alu_instr_t ins);
        int roll;
        roll = $urandom_range(9);
        if (roll < 3) begin
            return ins[`ALU_F_DEP_L_HI:`ALU_F_DEP_L_LO];
        end
        if (roll < 5) begin
            return ins[`ALU_F_DEP_R_HI:`ALU_F_DEP_R_LO];
        end
        return unit_index_t'($urandom_range(15));
    endfunction

    // Reference operand; cat is the behavior it exercises.
    function automatic operand_t resolve_operand(input alu_instr_t ins, input logic left,
                                                 output int cat);
        dep_tag_t  tag;
        logic      use_imm;
        reg_addr_t addr;
        tag     = left ? ins[`ALU_F_DEP_L_HI:`ALU_F_DEP_L_LO]
                       : ins[`ALU_F_DEP_R_HI:`ALU_F_DEP_R_LO];
        use_imm = left ? ins[`ALU_F_IMM_L_HI] : ins[`ALU_F_IMM_R_HI];
        addr    = left ? ins[`ALU_F_RS1_HI:`ALU_F_RS1_LO] : ins[`ALU_F_RS2_HI:`ALU_F_RS2_LO];
        cat = 2;
        if (use_imm) begin
            return ins[`ALU_F_IMM_HI:`ALU_F_IMM_LO];
        end
        cat = 3;
        if (tag == dep_tag_t'(`ALU_TAG_NONE)) begin
            return grf_value(addr, left);
        end
        cat = 5;
        if (tag == i_lsu_index) begin
            return i_lsu_data;
        end
        if (tag == i_csr_index) begin
            return i_csr_data;
        end
        if (tag == i_mul_index) begin
            return i_mul_data;
        end
        if (tag == i_div_index) begin
            return i_div_data;
        end
        cat = 4;
        return i_alu_bypass[tag];
    endfunction

    task automatic drive_inputs();
        alu_instr_t front;
        dep_tag_t   slot;
        i_valid     = (sent < NUM_INSTR) && ($urandom_range(9) < 7);
        i_instr     = make_instr();
        i_exe_ready = ($urandom_range(9) < 6);
        for (slot = 0; slot < dep_tag_t'(`ALU_BYPASS_SLOTS); slot++) begin
            i_alu_bypass[slot] = $urandom;
        end
        front       = (pend_q.size() > 0) ? pend_q[0] : i_instr;
        i_lsu_index = pick_index(front);
        i_csr_index = pick_index(front);
        i_mul_index = pick_index(front);
        i_div_index = pick_index(front);
        i_lsu_data  = $urandom;
        i_csr_data  = $urandom;
        i_mul_data  = $urandom;
        i_div_data  = $urandom;
    endtask

    // Handshakes of the current cycle, seen before the closing edge.
    task automatic observe_cycle();
        alu_instr_t ins;
        exe_instr_t exp;
        operand_t   op_l;
        operand_t   op_r;
        int         cat_l;
        int         cat_r;
        if (hold_check) begin
            check_flag(o_valid, 1'b1, 6, "o_valid");
            check_exe(o_exe_instr, held_word, 6, "o_exe_instr");
        end
        hold_check = o_valid && !i_exe_ready;
        held_word  = o_exe_instr;
        if (o_valid && i_exe_ready) begin
            if (exp_q.size() == 0) begin
                $display("Execute took a word while no instruction was outstanding");
                fail_cnt[6]++;
            end else begin
                exp   = exp_q.pop_front();
                cat_l = cat_l_q.pop_front();
                cat_r = cat_r_q.pop_front();
                check_exe(o_exe_instr, exp, 6, "o_exe_instr");
                check_operand(o_exe_instr[2*OPW-1:OPW], exp[2*OPW-1:OPW], cat_l, "left operand");
                check_operand(o_exe_instr[OPW-1:0], exp[OPW-1:0], cat_r, "right operand");
            end
            received++;
        end
        if (o_grf_rd_en) begin
            if (pend_q.size() == 0) begin
                $display("GRF read strobe raised while no instruction was in stage 1");
                fail_cnt[6]++;
            end else begin
                ins  = pend_q.pop_front();
                op_l = resolve_operand(ins, 1'b1, cat_l);
                op_r = resolve_operand(ins, 1'b0, cat_r);
                exp_q.push_back({ins, op_l, op_r});
                cat_l_q.push_back(cat_l);
                cat_r_q.push_back(cat_r);
            end
        end
        if (i_valid && o_ready) begin
            pend_q.push_back(i_instr);
            sent++;
        end
    endtask

    initial begin
        int t;
        int total_pass;
        int total_fail;
        void'($urandom(23));
        rstn          = 1'b0;
        i_valid       = 1'b0;
        i_instr       = '0;
        i_alu_bypass  = '0;
        i_lsu_index   = '0;
        i_csr_index   = '0;
        i_mul_index   = '0;
        i_div_index   = '0;
        i_lsu_data    = '0;
        i_csr_data    = '0;
        i_mul_data    = '0;
        i_div_data    = '0;
        i_exe_ready   = 1'b0;
        sent          = 0;
        received      = 0;
        cycles        = 0;
        timed_out     = 1'b0;
        hold_check    = 1'b0;
        held_word     = '0;

        repeat (5) @(negedge w_IssueFifoFire_1);
        rstn = 1'b1;
        #1;
        check_flag(o_valid, 1'b0, 1, "o_valid");
        check_flag(o_grf_rd_en, 1'b0, 1, "o_grf_rd_en");
        check_flag(o_ready, 1'b1, 1, "o_ready");
        report_test(1);

        while (received < NUM_INSTR && !timed_out) begin
            @(negedge w_IssueFifoFire_1);
            drive_inputs();
            #1;
            observe_cycle();
            cycles++;
            if (cycles >= CYCLE_LIMIT) begin
                timed_out = 1'b1;
            end
        end

        if (timed_out) begin
            $display("Timeout after %0d cycles, %0d of %0d instructions reached execute",
                     cycles, received, NUM_INSTR);
        end
        for (t = 2; t <= 6; t++) begin
            report_test(t);
        end
        total_pass = 0;
        total_fail = 0;
        for (t = 1; t <= 6; t++) begin
            total_pass += pass_cnt[t];
            total_fail += fail_cnt[t];
        end
        $display("Totals: %0d checks passed, %0d checks failed", total_pass, total_fail);
        if (!timed_out && total_fail == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+include
+incdir+bench
src/alu_issue_pkg.sv
src/issue_decode.sv
src/operand_select.sv
src/issue_output.sv
src/alu_issue_top.sv
bench/alu_issue_tb.sv

// File: include/alu_issue_params.svh
`ifndef ALU_ISSUE_PARAMS_SVH
`define ALU_ISSUE_PARAMS_SVH

`define ALU_INSTR_W      113
`define ALU_EXE_W        177
`define ALU_OPERAND_W    32
`define ALU_TAG_W        4
`define ALU_TAG_NONE     15
`define ALU_BYPASS_SLOTS 15
`define ALU_REG_W        5

// Instruction field positions.
`define ALU_F_DEP_R_HI   111
`define ALU_F_DEP_R_LO   108
`define ALU_F_DEP_L_HI   106
`define ALU_F_DEP_L_LO   103
`define ALU_F_IMM_L_HI   70
`define ALU_F_IMM_L_LO   70
`define ALU_F_IMM_R_HI   69
`define ALU_F_IMM_R_LO   69
`define ALU_F_RS1_HI     68
`define ALU_F_RS1_LO     64
`define ALU_F_RS2_HI     63
`define ALU_F_RS2_LO     59
`define ALU_F_IMM_HI     53
`define ALU_F_IMM_LO     22

`endif

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the ALU issue testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f files.f --top-module alu_issue_tb -o alu_issue_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/alu_issue_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "tests failed" sim.log; then
    exit 1
fi
exit 0

// File: src/alu_issue_pkg.sv
`include "alu_issue_params.svh"

package alu_issue_pkg;

    // Raw instruction from the issue queue.
    typedef logic [`ALU_INSTR_W-1:0] alu_instr_t;

    // Instruction on top, then left operand, then right operand.
    typedef logic [`ALU_EXE_W-1:0] exe_instr_t;

    typedef logic [`ALU_OPERAND_W-1:0] operand_t;

    typedef logic [`ALU_TAG_W-1:0] dep_tag_t;

    // Result index published by LSU, CSR, MUL or DIV.
    typedef logic [`ALU_TAG_W-1:0] unit_index_t;

    typedef logic [`ALU_REG_W-1:0] reg_addr_t;

    // ALU result slots, slot 0 lowest.
    typedef operand_t [`ALU_BYPASS_SLOTS-1:0] alu_bypass_bus_t;

endpackage

// File: src/alu_issue_top.sv
`timescale 1ns/1ps

module alu_issue_top
    import alu_issue_pkg::*;
(
    input  logic            w_IssueFifoFire_1,
    input  logic            rstn,

    input  logic            i_valid,
    input  alu_instr_t      i_instr,
    output logic            o_ready,

    output logic            o_grf_rd_en,
    output reg_addr_t       o_grf_rs1,
    output reg_addr_t       o_grf_rs2,
    input  operand_t        i_grf_rdata_l,
    input  operand_t        i_grf_rdata_r,

    input  alu_bypass_bus_t i_alu_bypass,
    input  unit_index_t     i_lsu_index,
    input  operand_t        i_lsu_data,
    input  unit_index_t     i_csr_index,
    input  operand_t        i_csr_data,
    input  unit_index_t     i_mul_index,
    input  operand_t        i_mul_data,
    input  unit_index_t     i_div_index,
    input  operand_t        i_div_data,

    output logic            o_valid,
    output exe_instr_t      o_exe_instr,
    input  logic            i_exe_ready
);

    logic       s1_valid;
    alu_instr_t s1_instr;
    logic       s2_ready;
    operand_t   operand_l;
    operand_t   operand_r;

    issue_decode u_decode (
        .w_IssueFifoFire_1 (w_IssueFifoFire_1),
        .rstn              (rstn),
        .i_valid           (i_valid),
        .i_instr           (i_instr),
        .o_ready           (o_ready),
        .i_s2_ready        (s2_ready),
        .o_s1_valid        (s1_valid),
        .o_s1_instr        (s1_instr),
        .o_grf_rd_en       (o_grf_rd_en),
        .o_grf_rs1         (o_grf_rs1),
        .o_grf_rs2         (o_grf_rs2)
    );

    operand_select u_sel_l (
        .i_instr      (s1_instr),
        .i_is_left    (1'b1),
        .i_grf_rdata  (i_grf_rdata_l),
        .i_alu_bypass (i_alu_bypass),
        .i_lsu_index  (i_lsu_index),
        .i_csr_index  (i_csr_index),
        .i_mul_index  (i_mul_index),
        .i_div_index  (i_div_index),
        .i_lsu_data   (i_lsu_data),
        .i_csr_data   (i_csr_data),
        .i_mul_data   (i_mul_data),
        .i_div_data   (i_div_data),
        .o_operand    (operand_l)
    );

    operand_select u_sel_r (
        .i_instr      (s1_instr),
        .i_is_left    (1'b0),
        .i_grf_rdata  (i_grf_rdata_r),
        .i_alu_bypass (i_alu_bypass),
        .i_lsu_index  (i_lsu_index),
        .i_csr_index  (i_csr_index),
        .i_mul_index  (i_mul_index),
        .i_div_index  (i_div_index),
        .i_lsu_data   (i_lsu_data),
        .i_csr_data   (i_csr_data),
        .i_mul_data   (i_mul_data),
        .i_div_data   (i_div_data),
        .o_operand    (operand_r)
    );

    issue_output u_output (
        .w_IssueFifoFire_1 (w_IssueFifoFire_1),
        .rstn              (rstn),
        .i_s1_valid        (s1_valid),
        .i_s1_instr        (s1_instr),
        .i_operand_l       (operand_l),
        .i_operand_r       (operand_r),
        .i_exe_ready       (i_exe_ready),
        .o_s2_ready        (s2_ready),
        .o_valid           (o_valid),
        .o_exe_instr       (o_exe_instr)
    );

endmodule

// File: src/issue_decode.sv
`timescale 1ns/1ps

`include "alu_issue_params.svh"

module issue_decode
    import alu_issue_pkg::*;
(
    input  logic       w_IssueFifoFire_1,
    input  logic       rstn,

    input  logic       i_valid,
    input  alu_instr_t i_instr,
    output logic       o_ready,

    input  logic       i_s2_ready,

    output logic       o_s1_valid,
    output alu_instr_t o_s1_instr,

    output logic       o_grf_rd_en,
    output reg_addr_t  o_grf_rs1,
    output reg_addr_t  o_grf_rs2
);

    logic       s1_valid;
    alu_instr_t s1_instr;
    logic       s1_load;

    // Stage 1 moves when empty or when stage 2 takes its content.
    assign o_ready = !s1_valid || i_s2_ready;
    assign s1_load = i_valid && o_ready;

    always_ff @(posedge w_IssueFifoFire_1 or negedge rstn) begin
        if (!rstn) begin
            s1_valid <= 1'b0;
        end else if (o_ready) begin
            s1_valid <= i_valid;
        end
    end

    always_ff @(posedge w_IssueFifoFire_1) begin
        if (s1_load) begin
            s1_instr <= i_instr;
        end
    end

    // GRF data is sampled into stage 2 on the edge that closes this cycle.
    assign o_grf_rd_en = s1_valid && i_s2_ready;
    assign o_grf_rs1   = s1_instr[`ALU_F_RS1_HI:`ALU_F_RS1_LO];
    assign o_grf_rs2   = s1_instr[`ALU_F_RS2_HI:`ALU_F_RS2_LO];

    assign o_s1_valid = s1_valid;
    assign o_s1_instr = s1_instr;

endmodule

// File: src/issue_output.sv
`timescale 1ns/1ps

module issue_output
    import alu_issue_pkg::*;
(
    input  logic       w_IssueFifoFire_1,
    input  logic       rstn,

    input  logic       i_s1_valid,
    input  alu_instr_t i_s1_instr,

    input  operand_t   i_operand_l,
    input  operand_t   i_operand_r,

    input  logic       i_exe_ready,
    output logic       o_s2_ready,

    output logic       o_valid,
    output exe_instr_t o_exe_instr
);

    logic       s2_valid;
    exe_instr_t s2_word;

    // Free when empty or when execute takes the current word.
    assign o_s2_ready = !s2_valid || i_exe_ready;

    always_ff @(posedge w_IssueFifoFire_1 or negedge rstn) begin
        if (!rstn) begin
            s2_valid <= 1'b0;
        end else if (o_s2_ready) begin
            s2_valid <= i_s1_valid;
        end
    end

    // Word holds while execute stalls.
    always_ff @(posedge w_IssueFifoFire_1) begin
        if (o_s2_ready && i_s1_valid) begin
            s2_word <= {i_s1_instr, i_operand_l, i_operand_r};
        end
    end

    assign o_valid     = s2_valid;
    assign o_exe_instr = s2_word;

endmodule

// File: src/operand_select.sv
`timescale 1ns/1ps

`include "alu_issue_params.svh"

module operand_select
    import alu_issue_pkg::*;
(
    input  alu_instr_t      i_instr,
    input  logic            i_is_left,

    input  operand_t        i_grf_rdata,
    input  alu_bypass_bus_t i_alu_bypass,

    input  unit_index_t     i_lsu_index,
    input  unit_index_t     i_csr_index,
    input  unit_index_t     i_mul_index,
    input  unit_index_t     i_div_index,

    input  operand_t        i_lsu_data,
    input  operand_t        i_csr_data,
    input  operand_t        i_mul_data,
    input  operand_t        i_div_data,

    output operand_t        o_operand
);

    dep_tag_t dep_tag;
    logic     use_imm;
    operand_t imm;

    // Pick this side's field set.
    assign dep_tag = i_is_left ? i_instr[`ALU_F_DEP_L_HI:`ALU_F_DEP_L_LO]
                               : i_instr[`ALU_F_DEP_R_HI:`ALU_F_DEP_R_LO];
    assign use_imm = i_is_left ? i_instr[`ALU_F_IMM_L_HI:`ALU_F_IMM_L_LO]
                               : i_instr[`ALU_F_IMM_R_HI:`ALU_F_IMM_R_LO];
    assign imm     = i_instr[`ALU_F_IMM_HI:`ALU_F_IMM_LO];

    always_comb begin
        if (use_imm) begin
            o_operand = imm;
        end else if (dep_tag == dep_tag_t'(`ALU_TAG_NONE)) begin
            o_operand = i_grf_rdata;
        // Functional units win over the ALU slots, LSU first.
        end else if (dep_tag == i_lsu_index) begin
            o_operand = i_lsu_data;
        end else if (dep_tag == i_csr_index) begin
            o_operand = i_csr_data;
        end else if (dep_tag == i_mul_index) begin
            o_operand = i_mul_data;
        end else if (dep_tag == i_div_index) begin
            o_operand = i_div_data;
        end else begin
            // Tag is 0 to 14 here.
            o_operand = i_alu_bypass[dep_tag];
        end
    end

endmodule
